/* vlog.f */
ex_pkg.sv
ex_alu.sv
ex_branch.sv
ex_csr.sv
ex_commit.sv
ex_stage.sv
tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - ex_pkg.sv
  - ex_alu.sv
  - ex_branch.sv
  - ex_csr.sv
  - ex_commit.sv
  - ex_stage.sv
  - target: simulation
    files:
      - tb_ex_stage.sv

/* tb_ex_stage.sv */
/*
 * self-checking testbench for the execute stage
 * reference model with shadow CSRs, xorshift stimulus, compare process
 */
`timescale 1ns/1ns
`default_nettype none

module tb_ex_stage;

    typedef struct packed {
        logic        valid;
        logic        en;
        logic [4:0]  addr;
        logic [63:0] data;
        logic        redir;
        logic [63:0] pc;
    } exp_t;

    localparam logic [63:0] MTVEC_INIT = 64'h0000_0000_0000_1000;

    logic              clk;
    logic              arst_n_i;
    logic              valid_i;
    ex_pkg::ex_op_e    op_i;
    logic [63:0]       pc_i;
    logic [63:0]       op1_i;
    logic [63:0]       op2_i;
    logic [63:0]       imm_i;
    logic              rd_en_i;
    logic [4:0]        rd_addr_i;
    logic              timer_irq_i;
    logic              hold_i;
    logic              wb_valid_o;
    logic              wb_en_o;
    logic [4:0]        wb_addr_o;
    logic [63:0]       wb_data_o;
    logic              redirect_o;
    logic [63:0]       redirect_pc_o;
    logic              flush_o;

    // shadow CSRs
    logic [63:0] sh_mstatus;
    logic [63:0] sh_mie;
    logic [63:0] sh_mtvec;
    logic [63:0] sh_mepc;
    logic [63:0] sh_mcause;
    logic [63:0] sh_mscratch;
    logic        sh_mtip;

    // instruction at the inputs before capture
    logic           p_valid;
    ex_pkg::ex_op_e p_op;
    logic [63:0]    p_pc;
    logic [63:0]    p_op1;
    logic [63:0]    p_op2;
    logic           p_irq;
    logic           pend_cap;
    exp_t           pend;
    exp_t           exp_q;

    logic [63:0] rng;
    int          errors;
    logic        checking;

    ex_stage #(
        .MTVEC_RESET (MTVEC_INIT)
    ) uut (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .valid_i       (valid_i),
        .op_i          (op_i),
        .pc_i          (pc_i),
        .op1_i         (op1_i),
        .op2_i         (op2_i),
        .imm_i         (imm_i),
        .rd_en_i       (rd_en_i),
        .rd_addr_i     (rd_addr_i),
        .timer_irq_i   (timer_irq_i),
        .hold_i        (hold_i),
        .wb_valid_o    (wb_valid_o),
        .wb_en_o       (wb_en_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .flush_o       (flush_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function logic [63:0] rand64();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 7);
        rng = rng ^ (rng << 17);
        return rng;
    endfunction

    function automatic logic [63:0] sx32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic logic [63:0] csr_read(input logic [11:0] a);
        case (a)
            12'h300: return sh_mstatus;
            12'h304: return sh_mie;
            12'h305: return sh_mtvec;
            12'h340: return sh_mscratch;
            12'h341: return sh_mepc;
            12'h342: return sh_mcause;
            12'h344: return {56'd0, sh_mtip, 7'd0};
            default: return 64'd0;
        endcase
    endfunction

    function automatic logic is_csr(input ex_pkg::ex_op_e op);
        return op == ex_pkg::OP_CSRRW || op == ex_pkg::OP_CSRRS || op == ex_pkg::OP_CSRRC;
    endfunction

    function automatic logic irq_taken(input logic v, input logic irq);
        return v && irq && sh_mstatus[3] && sh_mie[7];
    endfunction

    // expected outputs one cycle after capture
    function automatic exp_t model(input logic v, input ex_pkg::ex_op_e op,
                                   input logic [63:0] pc, input logic [63:0] a,
                                   input logic [63:0] b, input logic [63:0] imm,
                                   input logic rd_en, input logic [4:0] rd, input logic irq);
        exp_t        e;
        logic        tirq;
        logic        ecall;
        logic        mret;
        logic        taken;
        logic [63:0] d;
        logic [63:0] tgt;
        tirq  = irq_taken(v, irq);
        ecall = v && !tirq && op == ex_pkg::OP_ECALL;
        mret  = v && !tirq && op == ex_pkg::OP_MRET;
        taken = 1'b0;
        d     = 64'd0;
        case (op)
            ex_pkg::OP_ADD:   d = a + b;
            ex_pkg::OP_SUB:   d = a - b;
            ex_pkg::OP_SLT:   d = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            ex_pkg::OP_SLTU:  d = (a < b) ? 64'd1 : 64'd0;
            ex_pkg::OP_XOR:   d = a ^ b;
            ex_pkg::OP_OR:    d = a | b;
            ex_pkg::OP_AND:   d = a & b;
            ex_pkg::OP_SLL:   d = a << b[5:0];
            ex_pkg::OP_SRL:   d = a >> b[5:0];
            ex_pkg::OP_SRA:   d = $signed(a) >>> b[5:0];
            ex_pkg::OP_ADDW:  d = sx32(a[31:0] + b[31:0]);
            ex_pkg::OP_SUBW:  d = sx32(a[31:0] - b[31:0]);
            ex_pkg::OP_SLLW:  d = sx32(a[31:0] << b[4:0]);
            ex_pkg::OP_SRLW:  d = sx32(a[31:0] >> b[4:0]);
            ex_pkg::OP_SRAW:  d = sx32($signed(a[31:0]) >>> b[4:0]);
            ex_pkg::OP_LUI:   d = b;
            ex_pkg::OP_AUIPC: d = pc + b;
            ex_pkg::OP_JAL, ex_pkg::OP_JALR: begin
                d     = pc + 64'd4;
                taken = 1'b1;
            end
            ex_pkg::OP_BEQ:   taken = (a == b);
            ex_pkg::OP_BNE:   taken = (a != b);
            ex_pkg::OP_BLT:   taken = $signed(a) < $signed(b);
            ex_pkg::OP_BGE:   taken = $signed(a) >= $signed(b);
            ex_pkg::OP_BLTU:  taken = a < b;
            ex_pkg::OP_BGEU:  taken = a >= b;
            default:          d = 64'd0;
        endcase
        if (is_csr(op)) begin
            d = (op == ex_pkg::OP_CSRRW && rd == 5'd0) ? 64'd0 : csr_read(b[11:0]);
        end
        tgt = (op == ex_pkg::OP_JALR) ? ((a + imm) & ~64'd1) : pc + imm;
        e.valid = v;
        e.en    = v && rd_en && rd != 5'd0 && !tirq && !ecall;
        e.addr  = rd;
        e.data  = d;
        e.redir = v && (tirq || ecall || mret || taken);
        if (mret) begin
            e.pc = sh_mepc & ~64'd1;
        end else if (tirq || ecall) begin
            e.pc = sh_mtvec & ~64'd3;
        end else begin
            e.pc = tgt;
        end
        return e;
    endfunction

    task automatic apply_csr();
        logic        tirq;
        logic [63:0] w;
        tirq    = irq_taken(p_valid, p_irq);
        sh_mtip = p_irq;
        if (!p_valid) begin
            return;
        end
        if (tirq || p_op == ex_pkg::OP_ECALL) begin
            sh_mepc       = p_pc & ~64'd1;
            sh_mcause     = tirq ? 64'h8000_0000_0000_0007 : 64'd11;
            sh_mstatus[7] = sh_mstatus[3];
            sh_mstatus[3] = 1'b0;
        end else if (p_op == ex_pkg::OP_MRET) begin
            sh_mstatus[3] = sh_mstatus[7];
            sh_mstatus[7] = 1'b1;
        end else if (is_csr(p_op) && (p_op == ex_pkg::OP_CSRRW || p_op1 != 64'd0)) begin
            w = p_op1;
            if (p_op == ex_pkg::OP_CSRRS) w = csr_read(p_op2[11:0]) | p_op1;
            if (p_op == ex_pkg::OP_CSRRC) w = csr_read(p_op2[11:0]) & ~p_op1;
            case (p_op2[11:0])
                12'h300: sh_mstatus  = w;
                12'h304: sh_mie      = w;
                12'h305: sh_mtvec    = w;
                12'h340: sh_mscratch = w;
                12'h341: sh_mepc     = w & ~64'd1;
                12'h342: sh_mcause   = w;
                default: ;
            endcase
        end
    endtask

    // drives one clock of stimulus while the previous instruction is captured
    task automatic step(input logic v, input ex_pkg::ex_op_e op, input logic [63:0] pc,
                        input logic [63:0] a, input logic [63:0] b, input logic [63:0] imm,
                        input logic rd_en, input logic [4:0] rd, input logic irq,
                        input logic hold);
        @(posedge clk);
        if (pend_cap) begin
            exp_q = pend;
            apply_csr();
        end
        valid_i     <= v;
        op_i        <= op;
        pc_i        <= pc;
        op1_i       <= a;
        op2_i       <= b;
        imm_i       <= imm;
        rd_en_i     <= rd_en;
        rd_addr_i   <= rd;
        timer_irq_i <= irq;
        hold_i      <= hold;
        p_valid  = v;
        p_op     = op;
        p_pc     = pc;
        p_op1    = a;
        p_op2    = b;
        p_irq    = irq;
        pend     = model(v, op, pc, a, b, imm, rd_en, rd, irq);
        pend_cap = !hold;
    endtask

    task automatic idle();
        step(1'b0, ex_pkg::OP_NOP, 64'd0, 64'd0, 64'd0, 64'd0, 1'b0, 5'd0, 1'b0, 1'b0);
    endtask

    task automatic csr_op(input ex_pkg::ex_op_e op, input logic [11:0] a,
                          input logic [63:0] val, input logic [4:0] rd);
        step(1'b1, op, 64'h100, val, {52'd0, a}, 64'd0, 1'b1, rd, 1'b0, 1'b0);
    endtask

    task automatic wait_for_redirect();
        int n;
        n = 0;
        idle();
        @(negedge clk);
        while (!redirect_o && n < 8) begin
            idle();
            @(negedge clk);
            n++;
        end
        if (!redirect_o) begin
            $display("timeout while waiting for a redirect");
            errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            $display("FAIL %s exp %h got %h at %0t", name, want, got, $time);
            errors++;
        end
    endtask

    // outputs are stable at the falling edge
    initial begin
        int n;
        n = 0;
        while (!checking && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!checking) begin
            $display("reset was never released");
            errors++;
        end
        forever begin
            @(negedge clk);
            check_value("wb_valid_o", wb_valid_o, exp_q.valid);
            check_value("wb_en_o", wb_en_o, exp_q.en);
            check_value("redirect_o", redirect_o, exp_q.redir);
            check_value("flush_o", flush_o, exp_q.redir);
            if (exp_q.valid) begin
                check_value("wb_addr_o", wb_addr_o, exp_q.addr);
                check_value("wb_data_o", wb_data_o, exp_q.data);
            end
            if (exp_q.redir) begin
                check_value("redirect_pc_o", redirect_pc_o, exp_q.pc);
            end
        end
    end

    initial begin
        repeat (20000) @(posedge clk);
        $display("simulation timed out");
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic ex_pkg::ex_op_e alu_op_at(input int i);
        case (i)
            0: return ex_pkg::OP_ADD;
            1: return ex_pkg::OP_SUB;
            2: return ex_pkg::OP_SLT;
            3: return ex_pkg::OP_SLTU;
            4: return ex_pkg::OP_XOR;
            5: return ex_pkg::OP_OR;
            6: return ex_pkg::OP_AND;
            7: return ex_pkg::OP_SLL;
            8: return ex_pkg::OP_SRL;
            9: return ex_pkg::OP_SRA;
            10: return ex_pkg::OP_ADDW;
            11: return ex_pkg::OP_SUBW;
            12: return ex_pkg::OP_SLLW;
            13: return ex_pkg::OP_SRLW;
            14: return ex_pkg::OP_SRAW;
            15: return ex_pkg::OP_LUI;
            default: return ex_pkg::OP_AUIPC;
        endcase
    endfunction

    function automatic ex_pkg::ex_op_e br_op_at(input int i);
        case (i)
            0: return ex_pkg::OP_BEQ;
            1: return ex_pkg::OP_BNE;
            2: return ex_pkg::OP_BLT;
            3: return ex_pkg::OP_BGE;
            4: return ex_pkg::OP_BLTU;
            5: return ex_pkg::OP_BGEU;
            6: return ex_pkg::OP_JAL;
            default: return ex_pkg::OP_JALR;
        endcase
    endfunction

    initial begin
        logic [63:0] r;
        logic [63:0] a;
        logic [63:0] b;
        int          k;
        rng = 64'd68;
        errors = 0;
        checking = 1'b0;
        arst_n_i = 1'b0;
        valid_i = 1'b0;
        op_i = ex_pkg::OP_NOP;
        pc_i = '0;
        op1_i = '0;
        op2_i = '0;
        imm_i = '0;
        rd_en_i = 1'b0;
        rd_addr_i = '0;
        timer_irq_i = 1'b0;
        hold_i = 1'b0;
        sh_mstatus = '0;
        sh_mie = '0;
        sh_mtvec = MTVEC_INIT;
        sh_mepc = '0;
        sh_mcause = '0;
        sh_mscratch = '0;
        sh_mtip = 1'b0;
        p_valid = 1'b0;
        p_irq = 1'b0;
        pend_cap = 1'b0;
        pend = '0;
        exp_q = '0;
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;
        checking = 1'b1;
        idle();

        // random ALU traffic with rd x0 now and then
        for (int i = 0; i < 200; i++) begin
            r = rand64();
            a = rand64();
            b = r[1] ? rand64() : {58'd0, r[7:2]};
            step(1'b1, alu_op_at(int'(r[15:8] % 17)), (rand64() >> 8) << 2, a, b,
                 64'd0, r[16] | r[17], r[22:18], 1'b0, 1'b0);
        end

        // branches and jumps with equal operands half the time
        for (int i = 0; i < 80; i++) begin
            r = rand64();
            a = rand64();
            b = r[0] ? a : rand64();
            step(1'b1, br_op_at(int'(r[10:8])), (rand64() >> 8) << 2, a, b,
                 {{52{r[31]}}, r[31:21], 1'b0}, r[5], r[15:11], 1'b0, 1'b0);
        end

        // CSR access
        csr_op(ex_pkg::OP_CSRRW, 12'h340, 64'hdead_beef_0123_4567, 5'd5);
        csr_op(ex_pkg::OP_CSRRS, 12'h340, 64'd0, 5'd6);
        csr_op(ex_pkg::OP_CSRRS, 12'h340, 64'hf0, 5'd7);
        csr_op(ex_pkg::OP_CSRRC, 12'h340, 64'h0123, 5'd8);
        csr_op(ex_pkg::OP_CSRRC, 12'h340, 64'd0, 5'd9);
        csr_op(ex_pkg::OP_CSRRW, 12'h305, 64'h2000, 5'd0);
        csr_op(ex_pkg::OP_CSRRS, 12'h305, 64'd0, 5'd3);
        csr_op(ex_pkg::OP_CSRRW, 12'h304, 64'h88, 5'd4);
        csr_op(ex_pkg::OP_CSRRC, 12'h304, 64'h8, 5'd4);
        csr_op(ex_pkg::OP_CSRRS, 12'h304, 64'd0, 5'd4);

        // ECALL and then MRET with MIE set beforehand
        csr_op(ex_pkg::OP_CSRRS, 12'h300, 64'h8, 5'd0);
        step(1'b1, ex_pkg::OP_ECALL, 64'h4440, 64'd0, 64'd0, 64'd0, 1'b0, 5'd0, 1'b0, 1'b0);
        wait_for_redirect();
        csr_op(ex_pkg::OP_CSRRS, 12'h341, 64'd0, 5'd10);
        csr_op(ex_pkg::OP_CSRRS, 12'h342, 64'd0, 5'd11);
        csr_op(ex_pkg::OP_CSRRS, 12'h300, 64'd0, 5'd12);
        step(1'b1, ex_pkg::OP_MRET, 64'h5000, 64'd0, 64'd0, 64'd0, 1'b0, 5'd0, 1'b0, 1'b0);
        wait_for_redirect();
        csr_op(ex_pkg::OP_CSRRS, 12'h300, 64'd0, 5'd12);

        // timer interrupt and then again with MIE clear after the trap
        csr_op(ex_pkg::OP_CSRRS, 12'h304, 64'h80, 5'd0);
        step(1'b1, ex_pkg::OP_ADD, 64'h6000, 64'd1, 64'd2, 64'd0, 1'b1, 5'd1, 1'b1, 1'b0);
        wait_for_redirect();
        csr_op(ex_pkg::OP_CSRRS, 12'h342, 64'd0, 5'd2);
        step(1'b1, ex_pkg::OP_ADD, 64'h6100, 64'd3, 64'd4, 64'd0, 1'b1, 5'd1, 1'b1, 1'b0);
        step(1'b1, ex_pkg::OP_CSRRS, 64'h6104, 64'd0, 64'h342, 64'd0, 1'b1, 5'd2, 1'b0, 1'b0);

        // back-pressure on ALU and CSR writes
        for (int i = 0; i < 12; i++) begin
            r = rand64();
            a = rand64();
            k = 2 + int'(r[1:0]);
            for (int j = 0; j < k; j++) begin
                step(1'b1, r[2] ? ex_pkg::OP_CSRRW : alu_op_at(int'(r[15:8] % 17)),
                     64'h7000, a, r[2] ? 64'h340 : r[63:32], 64'd0, 1'b1, r[20:16],
                     1'b0, 1'b1);
            end
            step(1'b1, r[2] ? ex_pkg::OP_CSRRW : alu_op_at(int'(r[15:8] % 17)),
                 64'h7000, a, r[2] ? 64'h340 : r[63:32], 64'd0, 1'b1, r[20:16], 1'b0, 1'b0);
            csr_op(ex_pkg::OP_CSRRS, 12'h340, 64'd0, 5'd13);
        end

        repeat (3) idle();
        @(negedge clk);
        @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ex_stage.sv */
/*
 * execute stage top level
 * ALU, branch unit and CSR file in parallel, one commit register
 */
`timescale 1ns/1ns
`default_nettype none

module ex_stage #(
    parameter ex_pkg::xlen_t MTVEC_RESET = 64'h0000_0000_8000_0000
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              valid_i,
    input  ex_pkg::ex_op_e    op_i,
    input  ex_pkg::xlen_t     pc_i,
    input  ex_pkg::xlen_t     op1_i,
    input  ex_pkg::xlen_t     op2_i,
    input  ex_pkg::xlen_t     imm_i,
    input  logic              rd_en_i,
    input  ex_pkg::reg_addr_t rd_addr_i,
    input  logic              timer_irq_i,
    input  logic              hold_i,
    output logic              wb_valid_o,
    output logic              wb_en_o,
    output ex_pkg::reg_addr_t wb_addr_o,
    output ex_pkg::xlen_t     wb_data_o,
    output logic              redirect_o,
    output ex_pkg::xlen_t     redirect_pc_o,
    output logic              flush_o
);

    ex_pkg::xlen_t alu_result;
    logic          br_taken;
    ex_pkg::xlen_t br_target;
    ex_pkg::xlen_t csr_rdata;
    logic          trap_take;
    logic          trap_is_irq;
    logic          csr_redirect;
    ex_pkg::xlen_t csr_redirect_pc;

    ex_alu u_alu (
        .op_i     (op_i),
        .pc_i     (pc_i),
        .op1_i    (op1_i),
        .op2_i    (op2_i),
        .result_o (alu_result)
    );

    ex_branch u_branch (
        .op_i     (op_i),
        .pc_i     (pc_i),
        .op1_i    (op1_i),
        .op2_i    (op2_i),
        .imm_i    (imm_i),
        .taken_o  (br_taken),
        .target_o (br_target)
    );

    // CSR address comes in on op2
    ex_csr #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .valid_i       (valid_i),
        .op_i          (op_i),
        .pc_i          (pc_i),
        .op1_i         (op1_i),
        .csr_addr_i    (op2_i[11:0]),
        .rd_addr_i     (rd_addr_i),
        .timer_irq_i   (timer_irq_i),
        .hold_i        (hold_i),
        .rdata_o       (csr_rdata),
        .trap_o        (trap_take),
        .irq_o         (trap_is_irq),
        .redirect_o    (csr_redirect),
        .redirect_pc_o (csr_redirect_pc)
    );

    ex_commit u_commit (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .valid_i           (valid_i),
        .op_i              (op_i),
        .rd_en_i           (rd_en_i),
        .rd_addr_i         (rd_addr_i),
        .hold_i            (hold_i),
        .alu_result_i      (alu_result),
        .csr_rdata_i       (csr_rdata),
        .br_taken_i        (br_taken),
        .br_target_i       (br_target),
        .trap_i            (trap_take),
        .csr_redirect_i    (csr_redirect),
        .csr_redirect_pc_i (csr_redirect_pc),
        .wb_valid_o        (wb_valid_o),
        .wb_en_o           (wb_en_o),
        .wb_addr_o         (wb_addr_o),
        .wb_data_o         (wb_data_o),
        .redirect_o        (redirect_o),
        .redirect_pc_o     (redirect_pc_o),
        .flush_o           (flush_o)
    );

    // an accepted interrupt shows up as a cancelled, redirecting commit
    a_irq_cancels: assert property (@(posedge clk) disable iff (!arst_n_i)
        (valid_i && !hold_i && trap_is_irq) |=> (!wb_en_o && redirect_o));

endmodule

`default_nettype wire

/* ex_commit.sv */
/*
 * commit register of the execute stage
 * writeback select, redirect priority, output registers with hold
 */
`timescale 1ns/1ns
`default_nettype none

module ex_commit (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              valid_i,
    input  ex_pkg::ex_op_e    op_i,
    input  logic              rd_en_i,
    input  ex_pkg::reg_addr_t rd_addr_i,
    input  logic              hold_i,
    input  ex_pkg::xlen_t     alu_result_i,
    input  ex_pkg::xlen_t     csr_rdata_i,
    input  logic              br_taken_i,
    input  ex_pkg::xlen_t     br_target_i,
    input  logic              trap_i,
    input  logic              csr_redirect_i,
    input  ex_pkg::xlen_t     csr_redirect_pc_i,
    output logic              wb_valid_o,
    output logic              wb_en_o,
    output ex_pkg::reg_addr_t wb_addr_o,
    output ex_pkg::xlen_t     wb_data_o,
    output logic              redirect_o,
    output ex_pkg::xlen_t     redirect_pc_o,
    output logic              flush_o
);

    logic          is_csr_op;
    logic          wb_en_d;
    logic          redirect_d;
    ex_pkg::xlen_t wb_data_d;
    ex_pkg::xlen_t redirect_pc_d;

    assign is_csr_op = op_i inside {ex_pkg::OP_CSRRW, ex_pkg::OP_CSRRS, ex_pkg::OP_CSRRC};
    assign wb_data_d = is_csr_op ? csr_rdata_i : alu_result_i;

    // a trap cancels the instruction
    assign wb_en_d = valid_i && rd_en_i && rd_addr_i != '0 && !trap_i;

    // CSR redirect wins over the branch
    assign redirect_d    = valid_i && (csr_redirect_i || br_taken_i);
    assign redirect_pc_d = csr_redirect_i ? csr_redirect_pc_i : br_target_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_en_o    <= 1'b0;
            redirect_o <= 1'b0;
        end else if (!hold_i) begin
            wb_valid_o <= valid_i;
            wb_en_o    <= wb_en_d;
            redirect_o <= redirect_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            wb_addr_o     <= rd_addr_i;
            wb_data_o     <= wb_data_d;
            redirect_pc_o <= redirect_pc_d;
        end
    end

    assign flush_o = redirect_o;

    a_wb_en_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_en_o |-> wb_valid_o);

endmodule

`default_nettype wire

/* ex_csr.sv */
/*
 * machine mode CSR file
 * CSR read-modify-write, ECALL, MRET and timer interrupt entry
 */
`timescale 1ns/1ns
`default_nettype none

module ex_csr #(
    parameter ex_pkg::xlen_t MTVEC_RESET = 64'h0000_0000_8000_0000
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              valid_i,
    input  ex_pkg::ex_op_e    op_i,
    input  ex_pkg::xlen_t     pc_i,
    input  ex_pkg::xlen_t     op1_i,
    input  ex_pkg::csr_addr_t csr_addr_i,
    input  ex_pkg::reg_addr_t rd_addr_i,
    input  logic              timer_irq_i,
    input  logic              hold_i,
    output ex_pkg::xlen_t     rdata_o,
    output logic              trap_o,
    output logic              irq_o,
    output logic              redirect_o,
    output ex_pkg::xlen_t     redirect_pc_o
);

    typedef enum logic [1:0] {
        ACT_NONE,
        ACT_IRQ,
        ACT_ECALL,
        ACT_MRET
    } trap_act_e;

    ex_pkg::xlen_t mstatus_q;
    ex_pkg::xlen_t mie_q;
    ex_pkg::xlen_t mtvec_q;
    ex_pkg::xlen_t mepc_q;
    ex_pkg::xlen_t mcause_q;
    ex_pkg::xlen_t mscratch_q;
    logic          mtip_q;
    ex_pkg::xlen_t mip_val;
    ex_pkg::xlen_t csr_old;
    ex_pkg::xlen_t csr_wdata;
    logic          is_csr_op;
    logic          csr_rd_en;
    logic          csr_we;
    logic          accept;
    trap_act_e     act;

    assign accept = valid_i && !hold_i;

    always_comb begin
        mip_val = '0;
        mip_val[ex_pkg::MIE_MTIE] = mtip_q;
    end

    always_comb begin
        case (csr_addr_i)
            ex_pkg::CSR_MSTATUS:  csr_old = mstatus_q;
            ex_pkg::CSR_MIE:      csr_old = mie_q;
            ex_pkg::CSR_MIP:      csr_old = mip_val;
            ex_pkg::CSR_MTVEC:    csr_old = mtvec_q;
            ex_pkg::CSR_MEPC:     csr_old = mepc_q;
            ex_pkg::CSR_MCAUSE:   csr_old = mcause_q;
            ex_pkg::CSR_MSCRATCH: csr_old = mscratch_q;
            default:              csr_old = '0;
        endcase
    end

    // timer first, then ecall, then mret
    always_comb begin
        act = ACT_NONE;
        if (valid_i) begin
            if (timer_irq_i && mstatus_q[ex_pkg::MSTATUS_MIE] && mie_q[ex_pkg::MIE_MTIE]) begin
                act = ACT_IRQ;
            end else if (op_i == ex_pkg::OP_ECALL) begin
                act = ACT_ECALL;
            end else if (op_i == ex_pkg::OP_MRET) begin
                act = ACT_MRET;
            end
        end
    end

    always_comb begin
        case (op_i)
            ex_pkg::OP_CSRRS: csr_wdata = csr_old | op1_i;
            ex_pkg::OP_CSRRC: csr_wdata = csr_old & ~op1_i;
            default:          csr_wdata = op1_i;
        endcase
    end

    assign is_csr_op = op_i inside {ex_pkg::OP_CSRRW, ex_pkg::OP_CSRRS, ex_pkg::OP_CSRRC};
    // csrrw to x0 skips the read
    assign csr_rd_en = is_csr_op && !(op_i == ex_pkg::OP_CSRRW && rd_addr_i == '0);
    assign csr_we    = valid_i && act == ACT_NONE && is_csr_op
                       && (op_i == ex_pkg::OP_CSRRW || op1_i != '0);

    assign rdata_o       = csr_rd_en ? csr_old : '0;
    assign trap_o        = (act == ACT_IRQ) || (act == ACT_ECALL);
    assign irq_o         = (act == ACT_IRQ);
    assign redirect_o    = (act != ACT_NONE);
    assign redirect_pc_o = (act == ACT_MRET) ? mepc_q : {mtvec_q[63:2], 2'b00};

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtip_q <= 1'b0;
        end else if (!hold_i) begin
            mtip_q <= timer_irq_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mstatus_q  <= '0;
            mie_q      <= '0;
            mtvec_q    <= MTVEC_RESET;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mscratch_q <= '0;
        end else if (accept) begin
            case (act)
                ACT_IRQ, ACT_ECALL: begin
                    mepc_q   <= {pc_i[63:1], 1'b0};
                    mcause_q <= (act == ACT_IRQ) ? ex_pkg::CAUSE_TIMER_INT
                                                 : ex_pkg::CAUSE_ECALL_M;
                    mstatus_q[ex_pkg::MSTATUS_MPIE] <= mstatus_q[ex_pkg::MSTATUS_MIE];
                    mstatus_q[ex_pkg::MSTATUS_MIE]  <= 1'b0;
                end
                ACT_MRET: begin
                    // MPIE goes back to one as on real hardware
                    mstatus_q[ex_pkg::MSTATUS_MIE]  <= mstatus_q[ex_pkg::MSTATUS_MPIE];
                    mstatus_q[ex_pkg::MSTATUS_MPIE] <= 1'b1;
                end
                default: begin
                    if (csr_we) begin
                        case (csr_addr_i)
                            ex_pkg::CSR_MSTATUS:  mstatus_q  <= csr_wdata;
                            ex_pkg::CSR_MIE:      mie_q      <= csr_wdata;
                            ex_pkg::CSR_MTVEC:    mtvec_q    <= csr_wdata;
                            ex_pkg::CSR_MEPC:     mepc_q     <= {csr_wdata[63:1], 1'b0};
                            ex_pkg::CSR_MCAUSE:   mcause_q   <= csr_wdata;
                            ex_pkg::CSR_MSCRATCH: mscratch_q <= csr_wdata;
                            default: begin
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    a_no_write_on_trap: assert property (@(posedge clk) disable iff (!arst_n_i)
        (accept && trap_o) |=> ($stable(mie_q) && $stable(mtvec_q) && $stable(mscratch_q)));

    a_redirect_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        redirect_o |-> !redirect_pc_o[0]);

endmodule

`default_nettype wire

/* ex_branch.sv */
/*
 * branch compare and jump target computation
 */
`timescale 1ns/1ns
`default_nettype none

module ex_branch (
    input  ex_pkg::ex_op_e op_i,
    input  ex_pkg::xlen_t  pc_i,
    input  ex_pkg::xlen_t  op1_i,
    input  ex_pkg::xlen_t  op2_i,
    input  ex_pkg::xlen_t  imm_i,
    output logic           taken_o,
    output ex_pkg::xlen_t  target_o
);

    logic          eq;
    logic          lt_s;
    logic          lt_u;
    ex_pkg::xlen_t jalr_sum;

    assign eq   = (op1_i == op2_i);
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (op_i)
            ex_pkg::OP_BEQ:  taken_o = eq;
            ex_pkg::OP_BNE:  taken_o = !eq;
            ex_pkg::OP_BLT:  taken_o = lt_s;
            ex_pkg::OP_BGE:  taken_o = !lt_s;
            ex_pkg::OP_BLTU: taken_o = lt_u;
            ex_pkg::OP_BGEU: taken_o = !lt_u;
            ex_pkg::OP_JAL, ex_pkg::OP_JALR: begin
                taken_o = 1'b1;
            end
            default: taken_o = 1'b0;
        endcase
    end

    // jalr drops bit 0 of the sum
    assign jalr_sum = op1_i + imm_i;
    assign target_o = (op_i == ex_pkg::OP_JALR) ? {jalr_sum[63:1], 1'b0} : pc_i + imm_i;

endmodule

`default_nettype wire

/* ex_alu.sv */
/*
 * combinational 64-bit integer ALU
 * register, immediate and word operations, LUI, AUIPC
 * and the jump link value
 */
`timescale 1ns/1ns
`default_nettype none

module ex_alu (
    input  ex_pkg::ex_op_e op_i,
    input  ex_pkg::xlen_t  pc_i,
    input  ex_pkg::xlen_t  op1_i,
    input  ex_pkg::xlen_t  op2_i,
    output ex_pkg::xlen_t  result_o
);

    ex_pkg::xlen_t add_res;
    ex_pkg::xlen_t sub_res;
    logic [31:0]   addw_res;
    logic [31:0]   subw_res;
    logic [31:0]   sllw_res;
    logic [31:0]   srlw_res;
    logic [31:0]   sraw_res;
    logic [5:0]    shamt;
    logic [4:0]    shamt_w;

    function automatic ex_pkg::xlen_t sext32(input logic [31:0] val);
        sext32 = {{32{val[31]}}, val};
    endfunction

    assign shamt   = op2_i[5:0];
    assign shamt_w = op2_i[4:0];

    assign add_res = op1_i + op2_i;
    assign sub_res = op1_i - op2_i;

    // word forms work on the low half only
    assign addw_res = op1_i[31:0] + op2_i[31:0];
    assign subw_res = op1_i[31:0] - op2_i[31:0];
    assign sllw_res = op1_i[31:0] << shamt_w;
    assign srlw_res = op1_i[31:0] >> shamt_w;
    assign sraw_res = $signed(op1_i[31:0]) >>> shamt_w;

    always_comb begin
        case (op_i)
            ex_pkg::OP_ADD: begin
                result_o = add_res;
            end
            ex_pkg::OP_SUB: begin
                result_o = sub_res;
            end
            ex_pkg::OP_SLT: begin
                result_o = {63'd0, $signed(op1_i) < $signed(op2_i)};
            end
            ex_pkg::OP_SLTU: begin
                result_o = {63'd0, op1_i < op2_i};
            end
            ex_pkg::OP_XOR: begin
                result_o = op1_i ^ op2_i;
            end
            ex_pkg::OP_OR: begin
                result_o = op1_i | op2_i;
            end
            ex_pkg::OP_AND: begin
                result_o = op1_i & op2_i;
            end
            ex_pkg::OP_SLL: begin
                result_o = op1_i << shamt;
            end
            ex_pkg::OP_SRL: begin
                result_o = op1_i >> shamt;
            end
            ex_pkg::OP_SRA: begin
                result_o = $signed(op1_i) >>> shamt;
            end
            ex_pkg::OP_ADDW: begin
                result_o = sext32(addw_res);
            end
            ex_pkg::OP_SUBW: begin
                result_o = sext32(subw_res);
            end
            ex_pkg::OP_SLLW: begin
                result_o = sext32(sllw_res);
            end
            ex_pkg::OP_SRLW: begin
                result_o = sext32(srlw_res);
            end
            ex_pkg::OP_SRAW: begin
                result_o = sext32(sraw_res);
            end
            // op2 already holds the shifted upper immediate
            ex_pkg::OP_LUI: begin
                result_o = op2_i;
            end
            ex_pkg::OP_AUIPC: begin
                result_o = pc_i + op2_i;
            end
            // link value
            ex_pkg::OP_JAL, ex_pkg::OP_JALR: begin
                result_o = pc_i + 64'd4;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* ex_pkg.sv */
/*
 * shared types for the execute stage
 * word and index types, execute opcode enum,
 * machine CSR addresses, trap causes and CSR bit positions
 */
`default_nettype none

package ex_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    // immediate forms share the register codes
    typedef enum logic [5:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_OR,
        OP_AND,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADDW,
        OP_SUBW,
        OP_SLLW,
        OP_SRLW,
        OP_SRAW,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_ECALL,
        OP_MRET
    } ex_op_e;

    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MIP      = 12'h344;

    localparam xlen_t CAUSE_ECALL_M   = 64'd11;
    localparam xlen_t CAUSE_TIMER_INT = 64'h8000_0000_0000_0007;

    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    // mip.MTIP sits at the same position
    localparam int MIE_MTIE     = 7;

endpackage

`default_nettype wire
